// File: isa_pkg.sv
package isa_pkg;

    //----------------------------------------------------------------------
    // Architectural register file
    //----------------------------------------------------------------------

    // x0 is hardwired to zero and never renamed
    localparam int NUM_ARCH_REGS  = 32;
    localparam int REG_ADDR_WIDTH = $clog2(NUM_ARCH_REGS);

    // Integer data path width
    localparam int XLEN = 32;

    //----------------------------------------------------------------------
    // Micro-op classes
    //----------------------------------------------------------------------

    // Only the class matters to rename, it passes through untouched
    typedef enum logic [2:0] {
        UOP_ALU    = 3'd0,
        UOP_LOAD   = 3'd1,
        UOP_STORE  = 3'd2,
        UOP_BRANCH = 3'd3,
        UOP_MULDIV = 3'd4
    } uop_e;

endpackage

// File: rename_pkg.sv
package rename_pkg;

    import isa_pkg::*;

    //----------------------------------------------------------------------
    // Reorder buffer sizing
    //----------------------------------------------------------------------

    localparam int ROB_DEPTH = 16;
    localparam int TAG_WIDTH = $clog2(ROB_DEPTH);

    // Occupancy counter needs one extra bit to hold a full ROB
    localparam int CNT_WIDTH = TAG_WIDTH + 1;

    //----------------------------------------------------------------------
    // Pipeline payloads
    //----------------------------------------------------------------------

    // Decode output, reduced to what rename consumes
    typedef struct packed {
        logic                      is_valid;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [REG_ADDR_WIDTH-1:0] rs2;
        logic                      has_rd;
        uop_e                      uop;
    } decoded_inst_t;

    // Rename output handed to dispatch
    typedef struct packed {
        logic                 is_valid;
        uop_e                 uop;
        logic                 has_rd;
        logic [TAG_WIDTH-1:0] dest_tag;
        // Source 1
        logic                 rs1_renamed;
        logic [TAG_WIDTH-1:0] rs1_tag;
        logic [XLEN-1:0]      rs1_data;
        // Source 2
        logic                 rs2_renamed;
        logic [TAG_WIDTH-1:0] rs2_tag;
        logic [XLEN-1:0]      rs2_data;
    } renamed_inst_t;

endpackage

// File: rename_ifs.sv
`timescale 1ns/1ps

// Alias table lookup for one source operand
interface rat_read_if
    import isa_pkg::*, rename_pkg::*;
();
    logic [REG_ADDR_WIDTH-1:0] addr;
    logic                      renamed;
    logic [TAG_WIDTH-1:0]      tag;
    logic [XLEN-1:0]           data;

    modport client (output addr, input renamed, tag, data);
    modport tbl (input addr, output renamed, tag, data);
endinterface

// Speculative mapping update from rename
interface rat_write_if
    import isa_pkg::*, rename_pkg::*;
();
    logic                      we;
    logic [REG_ADDR_WIDTH-1:0] addr;
    logic [TAG_WIDTH-1:0]      tag;

    modport source (output we, addr, tag);
    modport sink (input we, addr, tag);
endinterface

// Retired result, seen by both the table and the allocator
interface commit_if
    import isa_pkg::*, rename_pkg::*;
();
    logic                      valid;
    logic [REG_ADDR_WIDTH-1:0] addr;
    logic [TAG_WIDTH-1:0]      tag;
    logic [XLEN-1:0]           data;
    logic                      has_rd;

    modport source (output valid, addr, tag, data, has_rd);
    modport sink (input valid, addr, tag, data, has_rd);
endinterface

// File: reg_alias_table.sv
`timescale 1ns/1ps

module reg_alias_table
    import isa_pkg::*, rename_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    rat_read_if.tbl   rs1_0,
    rat_read_if.tbl   rs2_0,
    rat_read_if.tbl   rs1_1,
    rat_read_if.tbl   rs2_1,
    rat_write_if.sink wr0,
    rat_write_if.sink wr1,
    commit_if.sink    c0,
    commit_if.sink    c1
);

    logic [NUM_ARCH_REGS-1:0] renamed_q;
    logic [TAG_WIDTH-1:0]     tag_q   [NUM_ARCH_REGS];
    logic [XLEN-1:0]          value_q [NUM_ARCH_REGS];
    logic                     c0_hit;
    logic                     c1_hit;

    // {renamed, tag, data}; x0 reads as a plain zero
    function automatic logic [TAG_WIDTH+XLEN:0] lookup(input logic [REG_ADDR_WIDTH-1:0] addr);
        logic [TAG_WIDTH+XLEN:0] result;
        result = '0;
        if (addr != '0) begin
            result = {renamed_q[addr], renamed_q[addr] ? tag_q[addr] : TAG_WIDTH'(0),
                      value_q[addr]};
        end
        return result;
    endfunction

    always_comb begin
        {rs1_0.renamed, rs1_0.tag, rs1_0.data} = lookup(rs1_0.addr);
        {rs2_0.renamed, rs2_0.tag, rs2_0.data} = lookup(rs2_0.addr);
        {rs1_1.renamed, rs1_1.tag, rs1_1.data} = lookup(rs1_1.addr);
        {rs2_1.renamed, rs2_1.tag, rs2_1.data} = lookup(rs2_1.addr);
    end

    //----------------------------------------------------------------------
    // Mapping state
    //----------------------------------------------------------------------

    // Only the youngest producer may release the mapping
    assign c0_hit = c0.valid && c0.has_rd && (c0.addr != '0) && renamed_q[c0.addr]
                    && (tag_q[c0.addr] == c0.tag);
    assign c1_hit = c1.valid && c1.has_rd && (c1.addr != '0) && renamed_q[c1.addr]
                    && (tag_q[c1.addr] == c1.tag);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            renamed_q <= '0;
        end else begin
            if (c0_hit) renamed_q[c0.addr] <= 1'b0;
            if (c1_hit) renamed_q[c1.addr] <= 1'b0;
            // Rename writes come last so they override a same-cycle commit
            if (wr0.we) renamed_q[wr0.addr] <= 1'b1;
            if (wr1.we) renamed_q[wr1.addr] <= 1'b1;
        end
    end

    // Slot 1 is younger and wins on a shared rd
    always_ff @(posedge clk) begin
        if (wr0.we) tag_q[wr0.addr] <= wr0.tag;
        if (wr1.we) tag_q[wr1.addr] <= wr1.tag;
    end

    // Committed values, kept across a flush
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                value_q[i] <= '0;
            end
        end else begin
            if (c0.valid && c0.has_rd && (c0.addr != '0)) value_q[c0.addr] <= c0.data;
            if (c1.valid && c1.has_rd && (c1.addr != '0)) value_q[c1.addr] <= c1.data;
        end
    end

    // Rename must filter x0 destinations before they reach the table
    a_no_write_x0: assert property (@(posedge clk) disable iff (reset)
        !(wr0.we && (wr0.addr == '0)) && !(wr1.we && (wr1.addr == '0)));

endmodule

// File: rob_allocator.sv
`timescale 1ns/1ps

module rob_allocator
    import rename_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic [1:0]           rob_alloc_req,
    commit_if.sink               c0,
    commit_if.sink               c1,
    output logic [1:0]           rob_alloc_gnt,
    output logic [TAG_WIDTH-1:0] rob_tag0,
    output logic [TAG_WIDTH-1:0] rob_tag1,
    output logic                 rob_full
);

    logic [TAG_WIDTH-1:0] tail_q;
    logic [CNT_WIDTH-1:0] count_q;
    logic [CNT_WIDTH-1:0] free_cnt;
    logic [1:0]           n_alloc;
    logic [1:0]           n_commit;

    assign free_cnt = CNT_WIDTH'(ROB_DEPTH) - count_q;
    assign rob_full = (count_q == CNT_WIDTH'(ROB_DEPTH));

    // In-order grant; slot 1 never passes a stalled slot 0
    always_comb begin
        rob_alloc_gnt[0] = rob_alloc_req[0] && (free_cnt != '0);
        rob_alloc_gnt[1] = rob_alloc_req[1] && (rob_alloc_gnt[0] || !rob_alloc_req[0])
                           && (free_cnt >= (rob_alloc_gnt[0] ? CNT_WIDTH'(2) : CNT_WIDTH'(1)));
    end

    // Consecutive tags from the tail
    assign rob_tag0 = tail_q;
    assign rob_tag1 = rob_alloc_gnt[0] ? tail_q + TAG_WIDTH'(1) : tail_q;

    assign n_alloc  = {1'b0, rob_alloc_gnt[0]} + {1'b0, rob_alloc_gnt[1]};
    assign n_commit = {1'b0, c0.valid} + {1'b0, c1.valid};

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            tail_q  <= tail_q + TAG_WIDTH'(n_alloc);
            count_q <= count_q + CNT_WIDTH'(n_alloc) - CNT_WIDTH'(n_commit);
        end
    end

    // Occupancy stays within the ROB
    a_count_max: assert property (@(posedge clk) disable iff (reset)
        count_q <= CNT_WIDTH'(ROB_DEPTH));

    // Commit side never retires more than is outstanding
    a_no_underflow: assert property (@(posedge clk) disable iff (reset || flush)
        ({1'b0, count_q} + n_alloc) >= n_commit);

endmodule

// File: rename_stage.sv
`timescale 1ns/1ps

module rename_stage
    import isa_pkg::*, rename_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  decoded_inst_t        dec0,
    input  decoded_inst_t        dec1,
    input  logic                 dispatch_rdy,
    input  logic [1:0]           rob_alloc_gnt,
    input  logic [TAG_WIDTH-1:0] rob_tag0,
    input  logic [TAG_WIDTH-1:0] rob_tag1,
    rat_read_if.client           rs1_0,
    rat_read_if.client           rs2_0,
    rat_read_if.client           rs1_1,
    rat_read_if.client           rs2_1,
    rat_write_if.source          wr0,
    rat_write_if.source          wr1,
    output logic                 decode_rdy,
    output renamed_inst_t        ren0,
    output renamed_inst_t        ren1,
    output logic                 rename_val,
    output logic [1:0]           rob_alloc_req
);

    // One looked-up source operand
    typedef struct packed {
        logic                 renamed;
        logic [TAG_WIDTH-1:0] tag;
        logic [XLEN-1:0]      data;
    } src_op_t;

    src_op_t       src1_0;
    src_op_t       src2_0;
    src_op_t       src1_1;
    src_op_t       src2_1;
    logic          can_rename0;
    logic          can_rename1;
    logic          fwd_ok;
    renamed_inst_t ren0_next;
    renamed_inst_t ren1_next;

    function automatic renamed_inst_t rename_inst(
        input decoded_inst_t        d,
        input src_op_t              s1,
        input src_op_t              s2,
        input logic [TAG_WIDTH-1:0] new_tag,
        input logic                 granted
    );
        renamed_inst_t r;
        r             = '0;
        r.is_valid    = granted;
        r.uop         = d.uop;
        r.has_rd      = d.has_rd;
        r.dest_tag    = new_tag;
        r.rs1_renamed = s1.renamed;
        r.rs1_tag     = s1.tag;
        r.rs1_data    = s1.data;
        r.rs2_renamed = s2.renamed;
        r.rs2_tag     = s2.tag;
        r.rs2_data    = s2.data;
        return r;
    endfunction

    //----------------------------------------------------------------------
    // Allocation and table lookup
    //----------------------------------------------------------------------

    assign decode_rdy    = dispatch_rdy;
    assign rob_alloc_req = {dec1.is_valid, dec0.is_valid} & {2{dispatch_rdy}};
    assign can_rename0   = rob_alloc_req[0] && rob_alloc_gnt[0];
    assign can_rename1   = rob_alloc_req[1] && rob_alloc_gnt[1];

    assign rs1_0.addr = dec0.rs1;
    assign rs2_0.addr = dec0.rs2;
    assign rs1_1.addr = dec1.rs1;
    assign rs2_1.addr = dec1.rs2;

    assign src1_0 = {rs1_0.renamed, rs1_0.tag, rs1_0.data};
    assign src2_0 = {rs2_0.renamed, rs2_0.tag, rs2_0.data};
    assign src1_1 = {rs1_1.renamed, rs1_1.tag, rs1_1.data};
    assign src2_1 = {rs2_1.renamed, rs2_1.tag, rs2_1.data};

    // inst0 produces a value that inst1 may need this same cycle
    assign fwd_ok = can_rename0 && dec0.has_rd && (dec0.rd != '0);

    always_comb begin
        ren0_next = rename_inst(dec0, src1_0, src2_0, rob_tag0, can_rename0);
        ren1_next = rename_inst(dec1, src1_1, src2_1, rob_tag1, can_rename1);
        if (fwd_ok && (dec1.rs1 == dec0.rd)) begin
            ren1_next.rs1_renamed = 1'b1;
            ren1_next.rs1_tag     = rob_tag0;
        end
        if (fwd_ok && (dec1.rs2 == dec0.rd)) begin
            ren1_next.rs2_renamed = 1'b1;
            ren1_next.rs2_tag     = rob_tag0;
        end
    end

    // New mappings with x0 destinations dropped
    assign wr0.we   = can_rename0 && dec0.has_rd && (dec0.rd != '0);
    assign wr0.addr = dec0.rd;
    assign wr0.tag  = rob_tag0;
    assign wr1.we   = can_rename1 && dec1.has_rd && (dec1.rd != '0);
    assign wr1.addr = dec1.rd;
    assign wr1.tag  = rob_tag1;

    //----------------------------------------------------------------------
    // Output register
    //----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ren0 <= '0;
            ren1 <= '0;
        end else if (dispatch_rdy) begin
            ren0 <= ren0_next;
            ren1 <= ren1_next;
        end
    end

    assign rename_val = ren0.is_valid || ren1.is_valid;

    // The allocator grants only requested slots
    a_gnt_has_req: assert property (@(posedge clk) disable iff (reset || flush)
        (rob_alloc_gnt & ~rob_alloc_req) == 2'b00);

    // Two table writes in one cycle carry consecutive ROB tags
    a_wr_tags: assert property (@(posedge clk) disable iff (reset || flush)
        (wr0.we && wr1.we) |-> (wr1.tag == wr0.tag + TAG_WIDTH'(1)));

endmodule

// File: rename_core.sv
`timescale 1ns/1ps

module rename_core
    import isa_pkg::*, rename_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  decoded_inst_t             dec0,
    input  decoded_inst_t             dec1,
    input  logic                      dispatch_rdy,
    input  logic                      commit0_valid,
    input  logic                      commit0_has_rd,
    input  logic [REG_ADDR_WIDTH-1:0] commit0_addr,
    input  logic [TAG_WIDTH-1:0]      commit0_tag,
    input  logic [XLEN-1:0]           commit0_data,
    input  logic                      commit1_valid,
    input  logic                      commit1_has_rd,
    input  logic [REG_ADDR_WIDTH-1:0] commit1_addr,
    input  logic [TAG_WIDTH-1:0]      commit1_tag,
    input  logic [XLEN-1:0]           commit1_data,
    output logic                      decode_rdy,
    output renamed_inst_t             ren0,
    output renamed_inst_t             ren1,
    output logic                      rename_val,
    output logic                      rob_full
);

    logic [1:0]           rob_alloc_req;
    logic [1:0]           rob_alloc_gnt;
    logic [TAG_WIDTH-1:0] rob_tag0;
    logic [TAG_WIDTH-1:0] rob_tag1;

    rat_read_if  rs1_0_if ();
    rat_read_if  rs2_0_if ();
    rat_read_if  rs1_1_if ();
    rat_read_if  rs2_1_if ();
    rat_write_if wr0_if ();
    rat_write_if wr1_if ();
    commit_if    c0_if ();
    commit_if    c1_if ();

    // Commit ports from the ROB
    assign c0_if.valid  = commit0_valid;
    assign c0_if.has_rd = commit0_has_rd;
    assign c0_if.addr   = commit0_addr;
    assign c0_if.tag    = commit0_tag;
    assign c0_if.data   = commit0_data;
    assign c1_if.valid  = commit1_valid;
    assign c1_if.has_rd = commit1_has_rd;
    assign c1_if.addr   = commit1_addr;
    assign c1_if.tag    = commit1_tag;
    assign c1_if.data   = commit1_data;

    rename_stage rename_stage_inst (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .dec0          (dec0),
        .dec1          (dec1),
        .dispatch_rdy  (dispatch_rdy),
        .rob_alloc_gnt (rob_alloc_gnt),
        .rob_tag0      (rob_tag0),
        .rob_tag1      (rob_tag1),
        .rs1_0         (rs1_0_if),
        .rs2_0         (rs2_0_if),
        .rs1_1         (rs1_1_if),
        .rs2_1         (rs2_1_if),
        .wr0           (wr0_if),
        .wr1           (wr1_if),
        .decode_rdy    (decode_rdy),
        .ren0          (ren0),
        .ren1          (ren1),
        .rename_val    (rename_val),
        .rob_alloc_req (rob_alloc_req)
    );

    reg_alias_table reg_alias_table_inst (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .rs1_0 (rs1_0_if),
        .rs2_0 (rs2_0_if),
        .rs1_1 (rs1_1_if),
        .rs2_1 (rs2_1_if),
        .wr0   (wr0_if),
        .wr1   (wr1_if),
        .c0    (c0_if),
        .c1    (c1_if)
    );

    rob_allocator rob_allocator_inst (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .rob_alloc_req (rob_alloc_req),
        .c0            (c0_if),
        .c1            (c1_if),
        .rob_alloc_gnt (rob_alloc_gnt),
        .rob_tag0      (rob_tag0),
        .rob_tag1      (rob_tag1),
        .rob_full      (rob_full)
    );

endmodule

// File: rename_checker.sv
`timescale 1ns/1ps

module rename_checker
    import isa_pkg::*, rename_pkg::*;
(
    input  logic          clk,
    input  logic          check_en,
    input  int            test_id,
    input  logic          dispatch_rdy,
    input  logic          decode_rdy,
    input  renamed_inst_t ren0,
    input  renamed_inst_t ren1,
    input  logic          rename_val,
    input  logic          rob_full,
    input  renamed_inst_t exp_ren0,
    input  renamed_inst_t exp_ren1,
    input  logic          exp_full,
    output int            error_count,
    output int            check_count
);

    int errors = 0;
    int checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    function automatic string test_name(input int id);
        case (id)
            0:       return "basic_rename";
            1:       return "group_forwarding";
            2:       return "commit";
            3:       return "rob_full";
            4:       return "back_pressure";
            5:       return "flush";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare_field(input string field, input logic [127:0] expected,
                                 input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s %s: expected %0h, actual %0h",
                     test_name(test_id), field, expected, actual);
        end
    endtask

    //----------------------------------------------------------------------
    // Compare in mid cycle, away from the driving edge
    //----------------------------------------------------------------------

    always @(negedge clk) begin
        if (check_en) begin
            compare_field("ren0", 128'(exp_ren0), 128'(ren0));
            compare_field("ren1", 128'(exp_ren1), 128'(ren1));
            // Any valid registered slot counts
            compare_field("rename_val", 128'(exp_ren0.is_valid || exp_ren1.is_valid),
                          128'(rename_val));
            compare_field("rob_full", 128'(exp_full), 128'(rob_full));
            compare_field("decode_rdy", 128'(dispatch_rdy), 128'(decode_rdy));
        end
    end

endmodule

// File: tb_rename.sv
`timescale 1ns/1ps

module tb_rename
    import isa_pkg::*, rename_pkg::*;
();

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_TESTS       = 6;
    localparam int TEST_CYCLES     = 2000;
    localparam int CYCLES_PER_TEST = TEST_CYCLES / NUM_TESTS;
    localparam int MARGIN_CYCLES   = 200;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES;
    localparam logic [31:0] SEED   = 32'h75ac_7f68;

    // Test ids, names live in the checker
    localparam int T_BASIC        = 0;
    localparam int T_FORWARD      = 1;
    localparam int T_COMMIT       = 2;
    localparam int T_ROB_FULL     = 3;
    localparam int T_BACKPRESSURE = 4;
    localparam int T_FLUSH        = 5;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]      tag;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic                      has_rd;
    } rob_entry_t;

    logic                      clk;
    logic                      reset;
    logic                      flush;
    decoded_inst_t             dec0;
    decoded_inst_t             dec1;
    logic                      dispatch_rdy;
    logic                      commit0_valid;
    logic                      commit0_has_rd;
    logic [REG_ADDR_WIDTH-1:0] commit0_addr;
    logic [TAG_WIDTH-1:0]      commit0_tag;
    logic [XLEN-1:0]           commit0_data;
    logic                      commit1_valid;
    logic                      commit1_has_rd;
    logic [REG_ADDR_WIDTH-1:0] commit1_addr;
    logic [TAG_WIDTH-1:0]      commit1_tag;
    logic [XLEN-1:0]           commit1_data;
    logic                      decode_rdy;
    renamed_inst_t             ren0;
    renamed_inst_t             ren1;
    logic                      rename_val;
    logic                      rob_full;

    // Model state, mirrors the DUT after the last clock edge
    logic                 m_renamed [NUM_ARCH_REGS];
    logic [TAG_WIDTH-1:0] m_tag     [NUM_ARCH_REGS];
    logic [XLEN-1:0]      m_value   [NUM_ARCH_REGS];
    int                   m_count;
    logic [TAG_WIDTH-1:0] m_tail;
    rob_entry_t           outstanding [$];

    // Prediction for the next edge, and the one the checker sees now
    renamed_inst_t pend_ren0;
    renamed_inst_t pend_ren1;
    int            pend_test;
    renamed_inst_t exp_ren0;
    renamed_inst_t exp_ren1;
    int            exp_test;
    logic          exp_full;
    logic          check_en;
    int            error_count;
    int            check_count;

    rename_core rename_core_inst (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .dec0           (dec0),
        .dec1           (dec1),
        .dispatch_rdy   (dispatch_rdy),
        .commit0_valid  (commit0_valid),
        .commit0_has_rd (commit0_has_rd),
        .commit0_addr   (commit0_addr),
        .commit0_tag    (commit0_tag),
        .commit0_data   (commit0_data),
        .commit1_valid  (commit1_valid),
        .commit1_has_rd (commit1_has_rd),
        .commit1_addr   (commit1_addr),
        .commit1_tag    (commit1_tag),
        .commit1_data   (commit1_data),
        .decode_rdy     (decode_rdy),
        .ren0           (ren0),
        .ren1           (ren1),
        .rename_val     (rename_val),
        .rob_full       (rob_full)
    );

    rename_checker rename_checker_inst (
        .clk          (clk),
        .check_en     (check_en),
        .test_id      (exp_test),
        .dispatch_rdy (dispatch_rdy),
        .decode_rdy   (decode_rdy),
        .ren0         (ren0),
        .ren1         (ren1),
        .rename_val   (rename_val),
        .rob_full     (rob_full),
        .exp_ren0     (exp_ren0),
        .exp_ren1     (exp_ren1),
        .exp_full     (exp_full),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //----------------------------------------------------------------------
    // Stimulus helpers
    //----------------------------------------------------------------------

    task automatic drive_idle();
        flush          = 1'b0;
        dispatch_rdy   = 1'b0;
        dec0           = '0;
        dec1           = '0;
        commit0_valid  = 1'b0;
        commit0_has_rd = 1'b0;
        commit0_addr   = '0;
        commit0_tag    = '0;
        commit0_data   = '0;
        commit1_valid  = 1'b0;
        commit1_has_rd = 1'b0;
        commit1_addr   = '0;
        commit1_tag    = '0;
        commit1_data   = '0;
    endtask

    // Registers 0..7 only, so hazards come often
    function automatic decoded_inst_t random_inst(input int valid_pct);
        decoded_inst_t d;
        d.is_valid = ($urandom_range(99, 0) < valid_pct);
        d.rd       = REG_ADDR_WIDTH'($urandom_range(7, 0));
        d.rs1      = REG_ADDR_WIDTH'($urandom_range(7, 0));
        d.rs2      = REG_ADDR_WIDTH'($urandom_range(7, 0));
        d.has_rd   = ($urandom_range(99, 0) < 80);
        d.uop      = uop_e'(3'($urandom_range(4, 0)));
        return d;
    endfunction

    // Table lookup per rename rules, x0 is never renamed and reads zero
    function automatic renamed_inst_t predict_slot(input decoded_inst_t d,
                                                   input logic [TAG_WIDTH-1:0] tag,
                                                   input logic granted);
        renamed_inst_t r;
        r          = '0;
        r.is_valid = granted;
        r.uop      = d.uop;
        r.has_rd   = d.has_rd;
        r.dest_tag = tag;
        if (d.rs1 != '0) begin
            r.rs1_renamed = m_renamed[d.rs1];
            r.rs1_tag     = m_renamed[d.rs1] ? m_tag[d.rs1] : '0;
            r.rs1_data    = m_value[d.rs1];
        end
        if (d.rs2 != '0) begin
            r.rs2_renamed = m_renamed[d.rs2];
            r.rs2_tag     = m_renamed[d.rs2] ? m_tag[d.rs2] : '0;
            r.rs2_data    = m_value[d.rs2];
        end
        return r;
    endfunction

    task automatic publish_expected();
        exp_ren0 = pend_ren0;
        exp_ren1 = pend_ren1;
        exp_test = pend_test;
        exp_full = (m_count == ROB_DEPTH);
    endtask

    //----------------------------------------------------------------------
    // One cycle of stimulus plus model update
    //----------------------------------------------------------------------

    task automatic run_cycle(input int test_id, input int cyc);
        decoded_inst_t        d0;
        decoded_inst_t        d1;
        logic                 rdy;
        logic                 do_flush;
        int                   commit_pct;
        int                   free_cnt;
        logic [1:0]           gnt;
        logic [TAG_WIDTH-1:0] tag0;
        logic [TAG_WIDTH-1:0] tag1;
        rob_entry_t           ce0;
        rob_entry_t           ce1;
        logic                 cv0;
        logic                 cv1;
        logic                 hit0;
        logic                 hit1;
        logic [XLEN-1:0]      cd0;
        logic [XLEN-1:0]      cd1;

        publish_expected();

        rdy      = (test_id == T_BACKPRESSURE) ? ($urandom_range(1, 0) == 1) : 1'b1;
        do_flush = (test_id == T_FLUSH) && ($urandom_range(99, 0) < 6);
        d0       = random_inst(do_flush ? 0 : 85);
        d1       = random_inst(do_flush ? 0 : 85);
        if (test_id == T_FORWARD) begin
            if ($urandom_range(99, 0) < 60) d1.rs1 = d0.rd;
            if ($urandom_range(99, 0) < 60) d1.rs2 = d0.rd;
        end

        // Commits withheld in bursts for the full-ROB test
        case (test_id)
            T_COMMIT:   commit_pct = 85;
            T_ROB_FULL: commit_pct = ((cyc % 80) < 40) ? 0 : 70;
            default:    commit_pct = 45;
        endcase
        if (do_flush) commit_pct = 0;

        cv0 = 1'b0;
        cv1 = 1'b0;
        ce0 = '0;
        ce1 = '0;
        cd0 = $urandom;
        cd1 = $urandom;
        if (outstanding.size() > 0 && $urandom_range(99, 0) < commit_pct) begin
            cv0 = 1'b1;
            ce0 = outstanding.pop_front();
        end
        if (cv0 && outstanding.size() > 0 && $urandom_range(99, 0) < commit_pct) begin
            cv1 = 1'b1;
            ce1 = outstanding.pop_front();
        end

        flush          = do_flush;
        dispatch_rdy   = rdy;
        dec0           = d0;
        dec1           = d1;
        commit0_valid  = cv0;
        commit0_has_rd = ce0.has_rd;
        commit0_addr   = ce0.rd;
        commit0_tag    = ce0.tag;
        commit0_data   = cd0;
        commit1_valid  = cv1;
        commit1_has_rd = ce1.has_rd;
        commit1_addr   = ce1.rd;
        commit1_tag    = ce1.tag;
        commit1_data   = cd1;

        // Grants in slot order
        free_cnt = ROB_DEPTH - m_count;
        gnt[0]   = d0.is_valid && rdy && (free_cnt >= 1);
        gnt[1]   = d1.is_valid && rdy && (gnt[0] || !(d0.is_valid && rdy))
                   && (free_cnt >= (gnt[0] ? 2 : 1));
        tag0     = m_tail;
        tag1     = gnt[0] ? m_tail + TAG_WIDTH'(1) : m_tail;

        if (do_flush) begin
            pend_ren0 = '0;
            pend_ren1 = '0;
        end else if (rdy) begin
            pend_ren0 = predict_slot(d0, tag0, gnt[0]);
            pend_ren1 = predict_slot(d1, tag1, gnt[1]);
            // inst1 reads inst0's result inside the group
            if (gnt[0] && d0.has_rd && (d0.rd != '0)) begin
                if (d1.rs1 == d0.rd) begin
                    pend_ren1.rs1_renamed = 1'b1;
                    pend_ren1.rs1_tag     = tag0;
                end
                if (d1.rs2 == d0.rd) begin
                    pend_ren1.rs2_renamed = 1'b1;
                    pend_ren1.rs2_tag     = tag0;
                end
            end
        end
        pend_test = test_id;

        if (do_flush) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                m_renamed[i] = 1'b0;
            end
            m_count = 0;
            m_tail  = '0;
            outstanding.delete();
        end else begin
            hit0 = cv0 && ce0.has_rd && (ce0.rd != '0) && m_renamed[ce0.rd]
                   && (m_tag[ce0.rd] == ce0.tag);
            hit1 = cv1 && ce1.has_rd && (ce1.rd != '0) && m_renamed[ce1.rd]
                   && (m_tag[ce1.rd] == ce1.tag);
            if (cv0 && ce0.has_rd && (ce0.rd != '0)) m_value[ce0.rd] = cd0;
            if (cv1 && ce1.has_rd && (ce1.rd != '0)) m_value[ce1.rd] = cd1;
            if (hit0) m_renamed[ce0.rd] = 1'b0;
            if (hit1) m_renamed[ce1.rd] = 1'b0;
            // New mappings override commits; slot 1 last
            if (gnt[0]) begin
                if (d0.has_rd && (d0.rd != '0)) begin
                    m_renamed[d0.rd] = 1'b1;
                    m_tag[d0.rd]     = tag0;
                end
                outstanding.push_back(rob_entry_t'{tag0, d0.rd, d0.has_rd});
            end
            if (gnt[1]) begin
                if (d1.has_rd && (d1.rd != '0)) begin
                    m_renamed[d1.rd] = 1'b1;
                    m_tag[d1.rd]     = tag1;
                end
                outstanding.push_back(rob_entry_t'{tag1, d1.rd, d1.has_rd});
            end
            m_count = m_count + int'(gnt[0]) + int'(gnt[1]) - int'(cv0) - int'(cv1);
            m_tail  = m_tail + TAG_WIDTH'(gnt[0]) + TAG_WIDTH'(gnt[1]);
        end
    endtask

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------

    initial begin
        reset    = 1'b1;
        check_en = 1'b0;
        drive_idle();
        void'($urandom(SEED));
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            m_renamed[i] = 1'b0;
            m_tag[i]     = '0;
            m_value[i]   = '0;
        end
        m_count   = 0;
        m_tail    = '0;
        pend_ren0 = '0;
        pend_ren1 = '0;
        pend_test = T_BASIC;
        publish_expected();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset    = 1'b0;
        check_en = 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int c = 0; c < CYCLES_PER_TEST; c++) begin
                run_cycle(t, c);
                @(posedge clk);
                #1;
            end
        end

        // Last registered pair is checked at the next falling edge
        publish_expected();
        drive_idle();
        @(negedge clk);
        #1;
        check_en = 1'b0;
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

// File: compile.f
isa_pkg.sv
rename_pkg.sv
rename_ifs.sv
reg_alias_table.sv
rob_allocator.sv
rename_stage.sv
rename_core.sv
rename_checker.sv
tb_rename.sv

// File: Makefile
SRCS := $(shell cat compile.f)

.PHONY: run clean

run: obj_dir/Vtb_rename
	@out=$$(./obj_dir/Vtb_rename); echo "$$out"; echo "$$out" | grep -qx "test passed"

obj_dir/Vtb_rename: compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rename -f compile.f

clean:
	rm -rf obj_dir
